// File: build.f
+incdir+testbench
src/tsn_tag_pkg.sv
src/frag_fetch.sv
src/port_len_table.sv
src/header_rewrite.sv
src/tsn_tag_replace_top.sv
testbench/tb_tsn_tag_replace.sv

// File: Makefile
BIN  := obj_dir/Vtb_tsn_tag_replace
SRCS := $(wildcard src/*.sv testbench/*.sv testbench/*.svh)

.PHONY: run clean

run: $(BIN)
	./$(BIN)

$(BIN): build.f $(SRCS)
	verilator --binary --timing -f build.f --top-module tb_tsn_tag_replace \
		-Mdir obj_dir -o Vtb_tsn_tag_replace

clean:
	rm -rf obj_dir

// File: testbench/tb_model.svh
// reference model of the tag replacement stage
// fragment generator and the value check
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

task automatic check_value(input string what, input pkt_word_t got, input pkt_word_t exp);
    if (got !== exp) begin
        report_failure($sformatf("ERROR %0t: %s, got %h, expected %h",
                                 $time, what, got, exp));
    end
endtask

function automatic pkt_word_t rand_word();
    return pkt_word_t'({$urandom, $urandom, $urandom, $urandom, $urandom});
endfunction

// one fragment into the FIFO models, predicted words into exp_q
task automatic add_fragment(input int port, input bit first, input int nwords,
                            input int total_len);
    pkt_word_t        w;
    pkt_word_t        e;
    logic [TAG_W-1:0] tag;
    logic [3:0]       seq;
    logic [15:0]      eth;
    int               nbytes;
    bit               drop;
    tag  = TAG_W'({$urandom, $urandom});
    seq  = 4'($urandom);
    drop = 1'b0;
    tag_q.push_back(tag);
    for (int i = 0; i < nwords; i++) begin
        w = rand_word();
        e = w;
        if (i == 0) begin
            w[133:132] = 2'b01;
            eth = 16'($urandom);
            if (eth == 16'h0800) begin
                eth = 16'h86dd;       // must not look like a first fragment
            end
            if (first) begin
                w[127:112] = 16'(total_len);
                w[31:16]   = 16'h0800;
                if (pend[port] != 0) begin
                    lost_tail_exp[port]++;
                end
                pend[port] = (total_len > 16) ? total_len - 16 : 0;
                e = w;
                e[111:64] = tag;
                e[31:16]  = 16'h1800;
            end else begin
                w[31:16] = eth;
                if (pend[port] == 0) begin
                    lost_head_exp[port]++;
                    drop = 1'b1;
                end else begin
                    pend[port] = (pend[port] > 16) ? pend[port] - 16 : 0;
                    e = w;
                    e[111:64]  = tag;
                    e[127:112] = 16'(pend[port]);
                    e[63:60]   = seq;
                end
            end
        end else if (i == nwords - 1) begin
            nbytes = $urandom_range(16, 1);
            w[133:132] = 2'b10;
            w[131:128] = 4'(nbytes);  // 16 is coded as 0
            e = w;
            if (!drop) begin
                pend[port] = (pend[port] > nbytes) ? pend[port] - nbytes : 0;
            end
        end else begin
            w[133:132] = 2'b11;
            e = w;
            if (!drop) begin
                pend[port] = (pend[port] > 16) ? pend[port] - 16 : 0;
            end
        end
        pkt_q.push_back(w);
        port_q.push_back(PORT_W'(port));
        seq_q.push_back(seq);
        if (!drop) begin
            exp_q.push_back(e);
        end
        n_words++;
    end
endtask

task automatic build_stimulus();
    int port;
    bit first;
    add_fragment(0, 1'b1, 3, 100);
    add_fragment(0, 1'b0, 2, 0);
    add_fragment(1, 1'b0, 3, 0);     // nothing pending, lost head
    add_fragment(2, 1'b1, 2, 200);
    add_fragment(2, 1'b1, 4, 64);    // bytes still pending, lost tail
    for (int k = 0; k < N_RAND; k++) begin
        port = $urandom_range(NUM_PORTS - 1, 0);
        if (pend[port] == 0) begin
            first = ($urandom_range(4, 0) != 0);
        end else begin
            first = ($urandom_range(4, 0) == 0);
        end
        add_fragment(port, first, $urandom_range(5, 2), $urandom_range(320, 32));
    end
endtask

`endif

// File: testbench/tb_tsn_tag_replace.sv
// testbench for the TSN tag replacement stage
// clock, reset, show-ahead FIFO models, DUT, scoreboard, watchdog
module tb_tsn_tag_replace import tsn_tag_pkg::*; ();

    localparam int NUM_PORTS = 8;
    localparam int PORT_W    = 3;
    localparam int N_RAND    = 150;

    logic                 clk;
    logic                 rst_n;
    logic [TAG_W-1:0]     i_tag_data;
    logic                 i_tag_empty;
    logic                 o_tag_rd;
    pkt_word_t            i_pkt_data;
    logic                 i_pkt_empty;
    logic [PORT_W-1:0]    i_inport;
    logic [3:0]           i_frag_seq;
    logic                 o_pkt_rd;
    pkt_word_t            o_pkt_data;
    logic                 o_pkt_wr;
    logic [NUM_PORTS-1:0] o_lost_head;
    logic [NUM_PORTS-1:0] o_lost_tail;

    // FIFO contents and model state
    logic [TAG_W-1:0]  tag_q [$];
    pkt_word_t         pkt_q [$];
    logic [PORT_W-1:0] port_q [$];
    logic [3:0]        seq_q [$];
    pkt_word_t         exp_q [$];
    int                pend [NUM_PORTS];
    int                lost_head_exp [NUM_PORTS];
    int                lost_tail_exp [NUM_PORTS];
    int                lost_head_cnt [NUM_PORTS];
    int                lost_tail_cnt [NUM_PORTS];
    int                n_words;
    bit                gen_done;
    bit                tag_rd_q;
    bit                pkt_rd_q;
    bit                tag_empty_q;
    bit                pkt_empty_q;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run aborted");
    endtask

    `include "tb_model.svh"

    tsn_tag_replace_top #(
        .NUM_PORTS (NUM_PORTS)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_tag_data  (i_tag_data),
        .i_tag_empty (i_tag_empty),
        .o_tag_rd    (o_tag_rd),
        .i_pkt_data  (i_pkt_data),
        .i_pkt_empty (i_pkt_empty),
        .i_inport    (i_inport),
        .i_frag_seq  (i_frag_seq),
        .o_pkt_rd    (o_pkt_rd),
        .o_pkt_data  (o_pkt_data),
        .o_pkt_wr    (o_pkt_wr),
        .o_lost_head (o_lost_head),
        .o_lost_tail (o_lost_tail)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // FIFO models
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        tag_rd_q    <= o_tag_rd;    // pops seen at this edge
        pkt_rd_q    <= o_pkt_rd;
        tag_empty_q <= i_tag_empty; // flags shown at that edge
        pkt_empty_q <= i_pkt_empty;
    end

    task automatic pop_fifos();
        if (tag_rd_q && (tag_empty_q || tag_q.size() == 0)) begin
            report_failure("DUT popped the tag FIFO while it was empty");
        end else if (pkt_rd_q && (pkt_empty_q || pkt_q.size() == 0)) begin
            report_failure("DUT popped the packet FIFO while it was empty");
        end else begin
            if (tag_rd_q) begin
                tag_q.delete(0);
            end
            if (pkt_rd_q) begin
                pkt_q.delete(0);
                port_q.delete(0);
                seq_q.delete(0);
            end
        end
    endtask

    // show-ahead outputs with random stalls
    task automatic drive_fifos();
        i_tag_empty = (tag_q.size() == 0) || ($urandom_range(3, 0) == 0);
        i_tag_data  = (tag_q.size() != 0) ? tag_q[0] : '0;
        i_pkt_empty = (pkt_q.size() == 0) || ($urandom_range(3, 0) == 0);
        if (pkt_q.size() != 0) begin
            i_pkt_data = pkt_q[0];
            i_inport   = port_q[0];
            i_frag_seq = seq_q[0];
        end
    endtask

    ////////////////////////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n) begin
            if (o_pkt_wr && exp_q.size() == 0) begin
                report_failure("output word written while none was expected");
            end else if (o_pkt_wr) begin
                check_value("output word", o_pkt_data, exp_q.pop_front());
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (o_lost_head[p]) lost_head_cnt[p]++;
                if (o_lost_tail[p]) lost_tail_cnt[p]++;
            end
        end
    end

    initial begin
        wait (gen_done);
        repeat (40 * n_words + 100) @(posedge clk);
        report_failure("watchdog timeout, the output stream stalled");
    end

    initial begin
        rst_n       = 1'b0;
        i_tag_data  = '0;
        i_tag_empty = 1'b1;
        i_pkt_data  = '0;
        i_pkt_empty = 1'b1;
        i_inport    = '0;
        i_frag_seq  = '0;
        void'($urandom(32'he58498d8));
        build_stimulus();
        gen_done = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // both FIFOs empty, nothing may move
        repeat (10) begin
            @(negedge clk);
            check_value("o_tag_rd while idle", pkt_word_t'(o_tag_rd), '0);
            check_value("o_pkt_rd while idle", pkt_word_t'(o_pkt_rd), '0);
            check_value("o_pkt_wr while idle", pkt_word_t'(o_pkt_wr), '0);
            check_value("loss pulses while idle", pkt_word_t'({o_lost_head, o_lost_tail}), '0);
        end
        while (pkt_q.size() != 0 || exp_q.size() != 0) begin
            pop_fifos();
            drive_fifos();
            @(negedge clk);
        end
        repeat (8) @(negedge clk);   // drain the pipeline
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("lost head pulses, port %0d", p),
                        pkt_word_t'(lost_head_cnt[p]), pkt_word_t'(lost_head_exp[p]));
            check_value($sformatf("lost tail pulses, port %0d", p),
                        pkt_word_t'(lost_tail_cnt[p]), pkt_word_t'(lost_tail_exp[p]));
        end
        check_value("words still expected", pkt_word_t'(exp_q.size()), '0);
        $display("Everything OK");
        $finish;
    end

endmodule

// File: src/tsn_tag_replace_top.sv
// top level of the TSN tag replacement stage
// fetch -> length table -> head rewrite
module tsn_tag_replace_top import tsn_tag_pkg::*; #(
    parameter  int NUM_PORTS = 8,
    localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // tag FIFO
    input  logic [TAG_W-1:0]     i_tag_data,
    input  logic                 i_tag_empty,
    output logic                 o_tag_rd,

    // packet FIFO
    input  pkt_word_t            i_pkt_data,
    input  logic                 i_pkt_empty,
    input  logic [PORT_W-1:0]    i_inport,
    input  logic [SEQ_W-1:0]     i_frag_seq,
    output logic                 o_pkt_rd,

    // output stream, no back-pressure
    output pkt_word_t            o_pkt_data,
    output logic                 o_pkt_wr,

    output logic [NUM_PORTS-1:0] o_lost_head,
    output logic [NUM_PORTS-1:0] o_lost_tail
);

    // fetch to table
    logic              word_valid;
    pkt_word_t         word_data;
    logic [PORT_W-1:0] word_port;
    logic [SEQ_W-1:0]  word_seq;
    logic [TAG_W-1:0]  frag_tag;

    // table to rewrite
    logic              fwd_valid;
    pkt_word_t         fwd_data;
    logic [TAG_W-1:0]  fwd_tag;
    logic [SEQ_W-1:0]  fwd_seq;
    logic              fwd_first;
    logic [LEN_W-1:0]  fwd_remain;

    frag_fetch #(
        .NUM_PORTS (NUM_PORTS)
    ) fetch_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_tag_data   (i_tag_data),
        .i_tag_empty  (i_tag_empty),
        .o_tag_rd     (o_tag_rd),
        .i_pkt_data   (i_pkt_data),
        .i_pkt_empty  (i_pkt_empty),
        .i_inport     (i_inport),
        .i_frag_seq   (i_frag_seq),
        .o_pkt_rd     (o_pkt_rd),
        .o_word_valid (word_valid),
        .o_word_data  (word_data),
        .o_word_port  (word_port),
        .o_word_seq   (word_seq),
        .o_frag_tag   (frag_tag)
    );

    port_len_table #(
        .NUM_PORTS (NUM_PORTS)
    ) table_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_word_valid (word_valid),
        .i_word_data  (word_data),
        .i_word_port  (word_port),
        .i_word_seq   (word_seq),
        .i_frag_tag   (frag_tag),
        .o_fwd_valid  (fwd_valid),
        .o_fwd_data   (fwd_data),
        .o_fwd_tag    (fwd_tag),
        .o_fwd_seq    (fwd_seq),
        .o_fwd_first  (fwd_first),
        .o_fwd_remain (fwd_remain),
        .o_lost_head  (o_lost_head),
        .o_lost_tail  (o_lost_tail)
    );

    header_rewrite rewrite_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_fwd_valid  (fwd_valid),
        .i_fwd_data   (fwd_data),
        .i_fwd_tag    (fwd_tag),
        .i_fwd_seq    (fwd_seq),
        .i_fwd_first  (fwd_first),
        .i_fwd_remain (fwd_remain),
        .o_pkt_data   (o_pkt_data),
        .o_pkt_wr     (o_pkt_wr)
    );

endmodule

// File: src/header_rewrite.sv
// output side of the tag replacement stage
// rewrites head words and registers the output stream
module header_rewrite import tsn_tag_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             i_fwd_valid,
    input  pkt_word_t        i_fwd_data,
    input  logic [TAG_W-1:0] i_fwd_tag,
    input  logic [SEQ_W-1:0] i_fwd_seq,
    input  logic             i_fwd_first,
    input  logic [LEN_W-1:0] i_fwd_remain,

    output pkt_word_t        o_pkt_data,
    output logic             o_pkt_wr
);

    word_kind_e kind;
    pkt_word_t  new_word;

    assign kind = word_kind_e'(i_fwd_data[KIND_LSB +: 2]);

    ////////////////////////////////////////////////////////////
    // head rewrite
    ////////////////////////////////////////////////////////////
    always_comb begin
        new_word = i_fwd_data;     // body and tail pass through
        if (kind == KIND_HEAD) begin
            new_word[TAG_LSB +: TAG_W] = i_fwd_tag;
            if (i_fwd_first) begin
                new_word[ETH_LSB +: ETH_W] = ETH_TSN;
            end else begin
                // later fragment carries what is left and its index
                new_word[LEN_LSB +: LEN_W] = i_fwd_remain;
                new_word[SEQ_LSB +: SEQ_W] = i_fwd_seq;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_pkt_wr <= 1'b0;
        end else begin
            o_pkt_wr <= i_fwd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fwd_valid) begin
            o_pkt_data <= new_word;
        end
    end

endmodule

// File: src/port_len_table.sv
// per-port remaining length table
// lost head / lost tail detection and fragment drop
module port_len_table import tsn_tag_pkg::*; #(
    parameter  int NUM_PORTS = 8,
    localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // word stream from fetch
    input  logic                 i_word_valid,
    input  pkt_word_t            i_word_data,
    input  logic [PORT_W-1:0]    i_word_port,
    input  logic [SEQ_W-1:0]     i_word_seq,
    input  logic [TAG_W-1:0]     i_frag_tag,

    // forwarded stream to the rewrite stage
    output logic                 o_fwd_valid,
    output pkt_word_t            o_fwd_data,
    output logic [TAG_W-1:0]     o_fwd_tag,
    output logic [SEQ_W-1:0]     o_fwd_seq,
    output logic                 o_fwd_first,
    output logic [LEN_W-1:0]     o_fwd_remain,

    // loss pulses, one bit per port
    output logic [NUM_PORTS-1:0] o_lost_head,
    output logic [NUM_PORTS-1:0] o_lost_tail
);

    localparam logic [LEN_W-1:0] STEP = LEN_W'(BYTES_PER_WORD);

    logic [LEN_W-1:0] len_tbl [NUM_PORTS];

    word_kind_e         kind;
    logic [LEN_W-1:0]   old_len;
    logic [LEN_W-1:0]   new_len;
    logic [LEN_W-1:0]   tail_bytes;
    logic [TBYTES_W-1:0] tail_field;
    logic               is_first;
    logic               upd;
    logic               drop_q;    // rest of fragment is discarded
    logic               drop_now;
    logic               lost_head;
    logic               lost_tail;

    function automatic logic [LEN_W-1:0] sat_sub(input logic [LEN_W-1:0] a,
                                                 input logic [LEN_W-1:0] b);
        return (a > b) ? a - b : '0;
    endfunction

    assign kind       = word_kind_e'(i_word_data[KIND_LSB +: 2]);
    assign old_len    = len_tbl[i_word_port];
    assign tail_field = i_word_data[TBYTES_LSB +: TBYTES_W];
    assign tail_bytes = (tail_field == '0) ? STEP : LEN_W'(tail_field);

    ////////////////////////////////////////////////////////////
    // next length and loss decision
    ////////////////////////////////////////////////////////////
    always_comb begin
        is_first  = 1'b0;
        upd       = 1'b0;
        lost_head = 1'b0;
        lost_tail = 1'b0;
        drop_now  = drop_q;
        new_len   = old_len;
        if (i_word_valid) begin
            case (kind)
                KIND_HEAD: begin
                    drop_now = 1'b0;
                    is_first = (i_word_data[ETH_LSB +: ETH_W] == ETH_IPV4);
                    if (is_first) begin
                        // restart the count from the packet length
                        new_len   = sat_sub(i_word_data[LEN_LSB +: LEN_W], STEP);
                        lost_tail = (old_len != '0);
                        upd       = 1'b1;
                    end else if (old_len == '0) begin
                        lost_head = 1'b1;
                        drop_now  = 1'b1;
                    end else begin
                        new_len = sat_sub(old_len, STEP);
                        upd     = 1'b1;
                    end
                end
                KIND_BODY: begin
                    new_len = sat_sub(old_len, STEP);
                    upd     = !drop_q;
                end
                KIND_TAIL: begin
                    new_len = sat_sub(old_len, tail_bytes);
                    upd     = !drop_q;
                end
                default: upd = 1'b0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // table and control registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                len_tbl[i] <= '0;
            end
            drop_q      <= 1'b0;
            o_fwd_valid <= 1'b0;
            o_lost_head <= '0;
            o_lost_tail <= '0;
        end else begin
            o_lost_head <= '0;
            o_lost_tail <= '0;
            o_fwd_valid <= i_word_valid && !drop_now;
            if (upd) begin
                len_tbl[i_word_port] <= new_len;
            end
            if (i_word_valid && kind == KIND_HEAD) begin
                drop_q <= drop_now;
            end else if (i_word_valid && kind == KIND_TAIL) begin
                drop_q <= 1'b0;
            end
            if (lost_head) begin
                o_lost_head[i_word_port] <= 1'b1;
            end
            if (lost_tail) begin
                o_lost_tail[i_word_port] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_word_valid) begin
            o_fwd_data   <= i_word_data;
            o_fwd_tag    <= i_frag_tag;
            o_fwd_seq    <= i_word_seq;
            o_fwd_first  <= is_first;
            o_fwd_remain <= new_len;   // value after the head's own step
        end
    end

endmodule

// File: src/frag_fetch.sv
// input side of the tag replacement stage
// pairs each head with a tag, pops fragment words until the tail
module frag_fetch import tsn_tag_pkg::*; #(
    parameter  int NUM_PORTS = 8,
    localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
    input  logic              clk,
    input  logic              rst_n,

    // tag FIFO, show-ahead
    input  logic [TAG_W-1:0]  i_tag_data,
    input  logic              i_tag_empty,
    output logic              o_tag_rd,

    // packet FIFO, show-ahead
    input  pkt_word_t         i_pkt_data,
    input  logic              i_pkt_empty,
    input  logic [PORT_W-1:0] i_inport,
    input  logic [SEQ_W-1:0]  i_frag_seq,
    output logic              o_pkt_rd,

    // word stream to the length table
    output logic              o_word_valid,
    output pkt_word_t         o_word_data,
    output logic [PORT_W-1:0] o_word_port,
    output logic [SEQ_W-1:0]  o_word_seq,
    output logic [TAG_W-1:0]  o_frag_tag
);

    typedef enum logic {
        ST_WAIT = 1'b0,   // waiting for a head
        ST_FRAG = 1'b1    // inside a fragment
    } fetch_state_e;

    fetch_state_e state;
    word_kind_e   in_kind;
    logic         pop_head;
    logic         pop_stray;
    logic         pop_frag;
    logic         pop_tail;

    assign in_kind = word_kind_e'(i_pkt_data[KIND_LSB +: 2]);

    ////////////////////////////////////////////////////////////
    // pop decisions
    ////////////////////////////////////////////////////////////
    // a head leaves the FIFO only together with its tag
    assign pop_head = (state == ST_WAIT) && !i_pkt_empty && !i_tag_empty &&
                      (in_kind == KIND_HEAD);

    // anything but a head at fragment start is out of frame, flush it
    assign pop_stray = (state == ST_WAIT) && !i_pkt_empty && (in_kind != KIND_HEAD);

    assign pop_frag = (state == ST_FRAG) && !i_pkt_empty;
    assign pop_tail = pop_frag && (in_kind == KIND_TAIL);

    assign o_tag_rd = pop_head;
    assign o_pkt_rd = pop_head | pop_stray | pop_frag;

    ////////////////////////////////////////////////////////////
    // fetch FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_WAIT;
            o_word_valid <= 1'b0;
        end else begin
            o_word_valid <= pop_head | pop_frag;
            case (state)
                ST_WAIT: begin
                    if (pop_head) begin
                        state <= ST_FRAG;
                    end
                end
                ST_FRAG: begin
                    if (pop_tail) begin
                        state <= ST_WAIT;
                    end
                end
                default: state <= ST_WAIT;
            endcase
        end
    end

    // payload, held per fragment
    always_ff @(posedge clk) begin
        if (pop_head | pop_frag) begin
            o_word_data <= i_pkt_data;
        end
        if (pop_head) begin
            o_frag_tag  <= i_tag_data;
            o_word_port <= i_inport;
            o_word_seq  <= i_frag_seq;
        end
    end

endmodule

// File: src/tsn_tag_pkg.sv
// shared definitions for the TSN tag replacement stage
// word layout, field positions, word kinds, ethertypes
package tsn_tag_pkg;

    localparam int WORD_W         = 134;
    localparam int TAG_W          = 48;
    localparam int LEN_W          = 16;
    localparam int SEQ_W          = 4;
    localparam int BYTES_PER_WORD = 16;

    ////////////////////////////////////////////////////////////
    // word kind, bits 133:132
    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        KIND_HEAD = 2'b01,
        KIND_BODY = 2'b11,
        KIND_TAIL = 2'b10
    } word_kind_e;

    localparam int KIND_LSB   = 132;
    localparam int TBYTES_LSB = 128;  // valid bytes on a tail, 0 means 16
    localparam int TBYTES_W   = 4;

    ////////////////////////////////////////////////////////////
    // head word fields
    ////////////////////////////////////////////////////////////
    localparam int LEN_LSB = 112;     // 127:112
    localparam int TAG_LSB = 64;      // 111:64
    localparam int SEQ_LSB = 60;      // 63:60
    localparam int ETH_LSB = 16;      // 31:16
    localparam int ETH_W   = 16;

    localparam logic [ETH_W-1:0] ETH_IPV4 = 16'h0800;  // first fragment
    localparam logic [ETH_W-1:0] ETH_TSN  = 16'h1800;

    typedef logic [WORD_W-1:0] pkt_word_t;

endpackage
